// File: hw/pad_pkg.sv
package pad_pkg;

  // ************************************************************
  // pad count and select encoding
  // ************************************************************

  // number of pads, one bit per pad in every group word
  localparam int unsigned N_IO = 8;

  // width of one per-pad mux select
  localparam int unsigned SEL_W = 2;

  // which peripheral group owns a pad
  // SEL_NONE leaves the pad tri-stated and is the reset value
  typedef enum logic [SEL_W-1:0] {
    SEL_PERIO  = 2'd0,
    SEL_APBIO  = 2'd1,
    SEL_FPGAIO = 2'd2,
    SEL_NONE   = 2'd3
  } pad_sel_e;

  // ************************************************************
  // group and pad bundles
  // ************************************************************

  // what one peripheral group drives toward the pads
  // bit i of out and oe belongs to pad i
  typedef struct packed {
    logic [N_IO-1:0] out;
    logic [N_IO-1:0] oe;
  } grp_drive_t;

  // one select per pad, entry i controls pad i
  typedef pad_sel_e [N_IO-1:0] pad_sel_vec_t;

endpackage

// File: hw/cfg_pkg.sv
package cfg_pkg;

  // ************************************************************
  // configuration write port
  // ************************************************************

  // width of the pad address in a configuration write
  localparam int unsigned PAD_W = $clog2(pad_pkg::N_IO);

  // default depth of the req and reset synchronizers
  // two flops are enough for the board reference clock
  localparam int unsigned SYNC_STAGES_DEF = 2;

  // data of one configuration write
  // held stable by the requester while req or ack is high
  typedef struct packed {
    logic [PAD_W-1:0]  pad;
    pad_pkg::pad_sel_e sel;
  } cfg_req_t;

  // handshake order seen from the register bank
  //  1. requester sets data, then raises req
  //  2. synchronized req rises, bank writes the select and raises ack
  //  3. requester drops req once ack is seen
  //  4. synchronized req falls, bank drops ack
  // a new write may start only after ack is low again

endpackage

// File: hw/clk_rst_gen.sv
`timescale 1ns/1ns

module clk_rst_gen #(
  parameter int unsigned SLOW_DIV    = 4,
  parameter int unsigned SYNC_STAGES = cfg_pkg::SYNC_STAGES_DEF
) (
  input  logic ref_clk_i,
  input  logic rst_n_i,
  output logic rst_n_o,
  output logic slow_clk_o
);

  // half period of the slow clock in reference cycles
  localparam int unsigned HALF_DIV = SLOW_DIV / 2;
  // counter must be at least one bit wide even for a divide by two
  localparam int unsigned CNT_W    = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(HALF_DIV - 1);

  // ************************************************************
  // reset release synchronizer
  // ************************************************************

  logic [SYNC_STAGES-1:0] rst_sync_q;

  // assertion is immediate, release walks through the chain
  // a one enters at stage 0 and reaches the last stage
  // on the SYNC_STAGES-th edge after rst_n_i goes high
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q[0] <= 1'b1;
      for (int k = 1; k < SYNC_STAGES; k++) begin
        rst_sync_q[k] <= rst_sync_q[k-1];
      end
    end
  end

  // synchronized reset for the rest of the safe domain
  assign rst_n_o = rst_sync_q[SYNC_STAGES-1];

  // ************************************************************
  // slow clock divider
  // ************************************************************

  logic [CNT_W-1:0] div_cnt_q;
  logic             slow_clk_q;

  // runs on the synchronized reset so the first high phase
  // always starts HALF_DIV cycles after release
  always_ff @(posedge ref_clk_i or negedge rst_n_o) begin
    if (!rst_n_o) begin
      div_cnt_q  <= '0;
      slow_clk_q <= 1'b0;
    end else if (div_cnt_q == CNT_MAX) begin
      // end of a half period, flip the output
      div_cnt_q  <= '0;
      slow_clk_q <= ~slow_clk_q;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  // registered output, glitch free
  assign slow_clk_o = slow_clk_q;

endmodule

// File: hw/pad_mux_regs.sv
`timescale 1ns/1ns

module pad_mux_regs #(
  parameter int unsigned SYNC_STAGES = cfg_pkg::SYNC_STAGES_DEF
) (
  input  logic                  ref_clk_i,
  // synchronized reset from clk_rst_gen
  input  logic                  rst_n_i,
  // configuration port, req level is asynchronous to ref_clk_i
  input  cfg_pkg::cfg_req_t     cfg_req_i,
  input  logic                  cfg_req_valid_i,
  output logic                  cfg_ack_o,
  // one mux select per pad toward pad_control
  output pad_pkg::pad_sel_vec_t pad_sel_o
);

  import pad_pkg::*;

  // ************************************************************
  // req synchronizer
  // ************************************************************

  logic [SYNC_STAGES-1:0] req_sync_q;
  logic                   req_sync;

  // plain level synchronizer
  // req is a slow four-phase level, no pulse can be lost
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q[0] <= cfg_req_valid_i;
      for (int k = 1; k < SYNC_STAGES; k++) begin
        req_sync_q[k] <= req_sync_q[k-1];
      end
    end
  end

  // last stage is the req level in the ref_clk_i domain
  assign req_sync = req_sync_q[SYNC_STAGES-1];

  // ************************************************************
  // ack generation
  // ************************************************************

  logic ack_q;
  logic req_rise;

  // ack follows the synchronized req one edge later
  // rises SYNC_STAGES+1 edges after req, falls the same way
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_sync;
    end
  end

  // new request seen but not yet acknowledged
  // true for exactly one cycle per write
  assign req_rise = req_sync & ~ack_q;

  assign cfg_ack_o = ack_q;

  // ************************************************************
  // per-pad select registers
  // ************************************************************

  pad_sel_vec_t pad_sel_q;

  // data is sampled only here, where req has been high for
  // SYNC_STAGES cycles and the requester keeps it stable
  // select changes on the same edge that raises ack
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int p = 0; p < N_IO; p++) begin
        pad_sel_q[p] <= SEL_NONE;
      end
    end else if (req_rise) begin
      pad_sel_q[cfg_req_i.pad] <= cfg_req_i.sel;
    end
  end

  assign pad_sel_o = pad_sel_q;

endmodule

// File: hw/pad_control.sv
`timescale 1ns/1ns

module pad_control (
  // per-pad mux selects from the register bank
  input  pad_pkg::pad_sel_vec_t         pad_sel_i,

  // group drives toward the pads
  input  pad_pkg::grp_drive_t           perio_drv_i,
  input  pad_pkg::grp_drive_t           apbio_drv_i,
  input  pad_pkg::grp_drive_t           fpgaio_drv_i,

  // pad side
  input  logic [pad_pkg::N_IO-1:0]      io_in_i,
  output logic [pad_pkg::N_IO-1:0]      io_out_o,
  output logic [pad_pkg::N_IO-1:0]      io_oe_o,

  // pad inputs steered back to the groups
  output logic [pad_pkg::N_IO-1:0]      perio_in_o,
  output logic [pad_pkg::N_IO-1:0]      apbio_in_o,
  output logic [pad_pkg::N_IO-1:0]      fpgaio_in_o
);

  import pad_pkg::*;

  // ************************************************************
  // output path, group to pad
  // ************************************************************

  // purely combinational, a select or drive change
  // reaches the pad in the same cycle
  always_comb begin
    // unused pads stay tri-stated with a low output
    io_out_o = '0;
    io_oe_o  = '0;
    for (int i = 0; i < N_IO; i++) begin
      case (pad_sel_i[i])
        SEL_PERIO: begin
          io_out_o[i] = perio_drv_i.out[i];
          io_oe_o[i]  = perio_drv_i.oe[i];
        end
        SEL_APBIO: begin
          io_out_o[i] = apbio_drv_i.out[i];
          io_oe_o[i]  = apbio_drv_i.oe[i];
        end
        SEL_FPGAIO: begin
          io_out_o[i] = fpgaio_drv_i.out[i];
          io_oe_o[i]  = fpgaio_drv_i.oe[i];
        end
        default: begin
          // SEL_NONE
          io_out_o[i] = 1'b0;
          io_oe_o[i]  = 1'b0;
        end
      endcase
    end
  end

  // ************************************************************
  // input path, pad to group
  // ************************************************************

  // pad i only ever lands on bit i of the selected group
  // the other two groups see zero on that bit
  always_comb begin
    perio_in_o  = '0;
    apbio_in_o  = '0;
    fpgaio_in_o = '0;
    for (int i = 0; i < N_IO; i++) begin
      case (pad_sel_i[i])
        SEL_PERIO: begin
          perio_in_o[i] = io_in_i[i];
        end
        SEL_APBIO: begin
          apbio_in_o[i] = io_in_i[i];
        end
        SEL_FPGAIO: begin
          fpgaio_in_o[i] = io_in_i[i];
        end
        default: begin
          // deselected pad, input is dropped for every group
          perio_in_o[i]  = 1'b0;
          apbio_in_o[i]  = 1'b0;
          fpgaio_in_o[i] = 1'b0;
        end
      endcase
    end
  end

endmodule

// File: hw/safe_domain.sv
`timescale 1ns/1ns

module safe_domain #(
  parameter int unsigned SLOW_DIV    = 4,
  parameter int unsigned SYNC_STAGES = cfg_pkg::SYNC_STAGES_DEF
) (
  input  logic                     ref_clk_i,
  input  logic                     rst_n_i,
  // synchronized reset for the rest of the SoC
  output logic                     rst_n_o,
  output logic                     slow_clk_o,

  // ************************************************************
  // configuration port
  // ************************************************************
  input  cfg_pkg::cfg_req_t        cfg_req_i,
  input  logic                     cfg_req_valid_i,
  output logic                     cfg_ack_o,

  // ************************************************************
  // peripheral groups
  // ************************************************************
  input  pad_pkg::grp_drive_t      perio_drv_i,
  input  pad_pkg::grp_drive_t      apbio_drv_i,
  input  pad_pkg::grp_drive_t      fpgaio_drv_i,
  output logic [pad_pkg::N_IO-1:0] perio_in_o,
  output logic [pad_pkg::N_IO-1:0] apbio_in_o,
  output logic [pad_pkg::N_IO-1:0] fpgaio_in_o,

  // pads
  input  logic [pad_pkg::N_IO-1:0] io_in_i,
  output logic [pad_pkg::N_IO-1:0] io_out_o,
  output logic [pad_pkg::N_IO-1:0] io_oe_o
);

  import pad_pkg::*;

  // selects from the register bank to the pad mux
  pad_sel_vec_t pad_sel;

  // reset release and slow clock
  clk_rst_gen #(
    .SLOW_DIV    (SLOW_DIV),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_clk_rst_gen (
    .ref_clk_i  (ref_clk_i),
    .rst_n_i    (rst_n_i),
    .rst_n_o    (rst_n_o),
    .slow_clk_o (slow_clk_o)
  );

  // bank runs on the synchronized reset
  pad_mux_regs #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_pad_mux_regs (
    .ref_clk_i       (ref_clk_i),
    .rst_n_i         (rst_n_o),
    .cfg_req_i       (cfg_req_i),
    .cfg_req_valid_i (cfg_req_valid_i),
    .cfg_ack_o       (cfg_ack_o),
    .pad_sel_o       (pad_sel)
  );

  pad_control u_pad_control (
    .pad_sel_i    (pad_sel),
    .perio_drv_i  (perio_drv_i),
    .apbio_drv_i  (apbio_drv_i),
    .fpgaio_drv_i (fpgaio_drv_i),
    .io_in_i      (io_in_i),
    .io_out_o     (io_out_o),
    .io_oe_o      (io_oe_o),
    .perio_in_o   (perio_in_o),
    .apbio_in_o   (apbio_in_o),
    .fpgaio_in_o  (fpgaio_in_o)
  );

endmodule

// File: dv/safe_domain_properties.sv
`timescale 1ns/1ns

module safe_domain_properties #(
  // 1 checks a req/ack pair, 0 checks a reset source and its synchronized copy
  parameter bit HS_MODE = 1'b1
) (
  input logic clk_i,
  input logic rst_n_i,
  // req in handshake mode, raw reset otherwise
  input logic a_i,
  // ack in handshake mode, synchronized reset otherwise
  input logic b_i
);

  // number of failed assertions in this instance
  int fail_cnt = 0;

  // ************************************************************
  // handshake and reset rules
  // ************************************************************

  if (HS_MODE) begin : g_handshake
    // ack may only rise in answer to a pending req
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(b_i) |-> $past(a_i))
      else begin
        fail_cnt++;
        $error("ack rose while req was low");
      end

    // ack may only fall once req has been withdrawn
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(b_i) |-> !$past(a_i))
      else begin
        fail_cnt++;
        $error("ack fell while req was still high");
      end
  end else begin : g_reset
    // synchronized reset never outlives the source reset
    assert property (@(posedge clk_i) !a_i |-> !b_i)
      else begin
        fail_cnt++;
        $error("synchronized reset high while reset input is low");
      end
  end

endmodule

bind pad_mux_regs safe_domain_properties #(.HS_MODE(1'b1)) u_hs_props (
  .clk_i   (ref_clk_i),
  .rst_n_i (rst_n_i),
  .a_i     (cfg_req_valid_i),
  .b_i     (cfg_ack_o)
);

bind clk_rst_gen safe_domain_properties #(.HS_MODE(1'b0)) u_rst_props (
  .clk_i   (ref_clk_i),
  .rst_n_i (1'b1),
  .a_i     (rst_n_i),
  .b_i     (rst_n_o)
);

// File: dv/safe_domain_checker.sv
`timescale 1ns/1ns

module safe_domain_checker #(
  parameter int unsigned SLOW_DIV    = 4,
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic                     ref_clk_i,
  input  logic                     rst_n_i,
  input  logic                     dut_rst_n_i,
  input  logic                     slow_clk_i,
  input  cfg_pkg::cfg_req_t        cfg_req_i,
  input  logic                     cfg_req_valid_i,
  input  logic                     cfg_ack_i,
  input  pad_pkg::grp_drive_t      perio_drv_i,
  input  pad_pkg::grp_drive_t      apbio_drv_i,
  input  pad_pkg::grp_drive_t      fpgaio_drv_i,
  input  logic [pad_pkg::N_IO-1:0] perio_in_i,
  input  logic [pad_pkg::N_IO-1:0] apbio_in_i,
  input  logic [pad_pkg::N_IO-1:0] fpgaio_in_i,
  input  logic [pad_pkg::N_IO-1:0] io_in_i,
  input  logic [pad_pkg::N_IO-1:0] io_out_i,
  input  logic [pad_pkg::N_IO-1:0] io_oe_i,
  output int                       err_cnt_o,
  output int                       chk_cnt_o
);

  import pad_pkg::*;

  // select of each pad as seen from the handshake captures
  pad_sel_vec_t sel_mirror = {N_IO{SEL_NONE}};
  string        test_name  = "reset";
  bit           write_seen = 1'b0;
  bit           slow_seen  = 1'b0;
  int           err_cnt    = 0;
  int           chk_cnt    = 0;
  int           rst_edges  = 0;
  int           req_edges  = 0;
  int           slow_edges = 0;
  logic         req_prev   = 1'b0;
  logic         ack_prev   = 1'b0;
  logic         rst_prev   = 1'b0;
  logic         slow_prev  = 1'b0;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic report(input string what, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("error %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // ************************************************************
  // routing model
  // ************************************************************

  // every pad follows its mirrored select, unused pads stay at zero
  task automatic compare_routing();
    logic [N_IO-1:0] e_out;
    logic [N_IO-1:0] e_oe;
    logic [N_IO-1:0] e_per;
    logic [N_IO-1:0] e_apb;
    logic [N_IO-1:0] e_fpg;
    e_out = '0;
    e_oe  = '0;
    e_per = '0;
    e_apb = '0;
    e_fpg = '0;
    for (int i = 0; i < N_IO; i++) begin
      if (sel_mirror[i] == SEL_PERIO) begin
        e_out[i] = perio_drv_i.out[i];
        e_oe[i]  = perio_drv_i.oe[i];
        e_per[i] = io_in_i[i];
      end else if (sel_mirror[i] == SEL_APBIO) begin
        e_out[i] = apbio_drv_i.out[i];
        e_oe[i]  = apbio_drv_i.oe[i];
        e_apb[i] = io_in_i[i];
      end else if (sel_mirror[i] == SEL_FPGAIO) begin
        e_out[i] = fpgaio_drv_i.out[i];
        e_oe[i]  = fpgaio_drv_i.oe[i];
        e_fpg[i] = io_in_i[i];
      end
    end
    report("io_out", 32'(e_out), 32'(io_out_i));
    report("io_oe", 32'(e_oe), 32'(io_oe_i));
    report("perio_in", 32'(e_per), 32'(perio_in_i));
    report("apbio_in", 32'(e_apb), 32'(apbio_in_i));
    report("fpgaio_in", 32'(e_fpg), 32'(fpgaio_in_i));
  endtask

  // table expectation for the addressed pad, ins ordered perio, apbio, fpgaio
  task automatic compare_pad(input int pad, input logic e_out, input logic e_oe,
                             input logic [2:0] e_in);
    logic [2:0] act_in;
    act_in = {perio_in_i[pad], apbio_in_i[pad], fpgaio_in_i[pad]};
    report("pad out", 32'(e_out), 32'(io_out_i[pad]));
    report("pad oe", 32'(e_oe), 32'(io_oe_i[pad]));
    report("pad inputs", 32'(e_in), 32'(act_in));
  endtask

  // ************************************************************
  // edge counters
  // ************************************************************

  // inputs settle 2 ns after the edge, so this sees the driven levels
  always @(posedge ref_clk_i) begin
    if (!rst_n_i) begin
      rst_edges = 0;
    end else begin
      rst_edges++;
    end
    // count from the edge that first sees a new req level
    if (cfg_req_valid_i !== req_prev) begin
      req_edges = 1;
    end else begin
      req_edges++;
    end
    req_prev = cfg_req_valid_i;
    slow_edges++;
  end

  // mid-cycle sampling, all registered and routed values are stable
  always @(negedge ref_clk_i) begin
    if (dut_rst_n_i && !rst_prev && rst_n_i) begin
      report("reset release edges", 32'(SYNC_STAGES), 32'(rst_edges));
    end
    rst_prev = dut_rst_n_i;
    if (!dut_rst_n_i) begin
      sel_mirror = {N_IO{SEL_NONE}};
      write_seen = 1'b0;
      slow_seen  = 1'b0;
      slow_edges = 0;
      // divider output held low until the synchronized release
      report("slow clock in reset", 32'd0, 32'(slow_clk_i));
    end else begin
      if (cfg_ack_i && !ack_prev) begin
        report("ack rise edges", 32'(SYNC_STAGES + 1), 32'(req_edges));
        // select takes effect on the ack edge
        sel_mirror[cfg_req_i.pad] = cfg_req_i.sel;
        write_seen = 1'b1;
      end
      if (!cfg_ack_i && ack_prev) begin
        report("ack fall edges", 32'(SYNC_STAGES + 1), 32'(req_edges));
      end
      if (!write_seen) begin
        report("idle ack", 32'd0, 32'(cfg_ack_i));
      end
      compare_routing();
      // first toggle only sets the phase
      if (slow_clk_i !== slow_prev) begin
        if (slow_seen) begin
          report("slow clock half period", 32'(SLOW_DIV / 2), 32'(slow_edges));
        end
        slow_seen  = 1'b1;
        slow_edges = 0;
      end else if (slow_edges > SLOW_DIV) begin
        // a whole slow period went by without a transition
        report("slow clock stuck edges", 32'(SLOW_DIV / 2), 32'(slow_edges));
        slow_edges = 0;
      end
    end
    ack_prev  = cfg_ack_i;
    slow_prev = slow_clk_i;
  end

endmodule

// File: dv/tb_safe_domain.sv
`timescale 1ns/1ns

module tb_safe_domain;

  import pad_pkg::*;
  import cfg_pkg::*;

  localparam int unsigned SLOW_DIV    = 4;
  localparam int unsigned SYNC_STAGES = SYNC_STAGES_DEF;
  localparam int unsigned N_RAND      = 8;

  // one stimulus row, expectations only for the addressed pad
  typedef struct {
    string            name;
    logic [PAD_W-1:0] pad;
    pad_sel_e         sel;
    grp_drive_t       perio;
    grp_drive_t       apbio;
    grp_drive_t       fpgaio;
    logic [N_IO-1:0]  io_in;
    bit               fixed;
    logic             e_out;
    logic             e_oe;
    logic [2:0]       e_in;
  } row_t;

  row_t rows[$];

  logic            ref_clk = 1'b0;
  logic            rst_n   = 1'b0;
  logic            rst_n_o;
  logic            slow_clk;
  cfg_req_t        cfg_req = '0;
  logic            cfg_req_valid = 1'b0;
  logic            cfg_ack;
  grp_drive_t      perio_drv  = '0;
  grp_drive_t      apbio_drv  = '0;
  grp_drive_t      fpgaio_drv = '0;
  logic [N_IO-1:0] perio_in;
  logic [N_IO-1:0] apbio_in;
  logic [N_IO-1:0] fpgaio_in;
  logic [N_IO-1:0] io_in = '0;
  logic [N_IO-1:0] io_out;
  logic [N_IO-1:0] io_oe;
  int              err_cnt;
  int              chk_cnt;

  always #20 ref_clk = ~ref_clk;

  safe_domain #(.SLOW_DIV(SLOW_DIV), .SYNC_STAGES(SYNC_STAGES)) u_dut (
    .ref_clk_i(ref_clk), .rst_n_i(rst_n), .rst_n_o(rst_n_o), .slow_clk_o(slow_clk),
    .cfg_req_i(cfg_req), .cfg_req_valid_i(cfg_req_valid), .cfg_ack_o(cfg_ack),
    .perio_drv_i(perio_drv), .apbio_drv_i(apbio_drv), .fpgaio_drv_i(fpgaio_drv),
    .perio_in_o(perio_in), .apbio_in_o(apbio_in), .fpgaio_in_o(fpgaio_in),
    .io_in_i(io_in), .io_out_o(io_out), .io_oe_o(io_oe)
  );

  safe_domain_checker #(.SLOW_DIV(SLOW_DIV), .SYNC_STAGES(SYNC_STAGES)) u_checker (
    .ref_clk_i(ref_clk), .rst_n_i(rst_n), .dut_rst_n_i(rst_n_o), .slow_clk_i(slow_clk),
    .cfg_req_i(cfg_req), .cfg_req_valid_i(cfg_req_valid), .cfg_ack_i(cfg_ack),
    .perio_drv_i(perio_drv), .apbio_drv_i(apbio_drv), .fpgaio_drv_i(fpgaio_drv),
    .perio_in_i(perio_in), .apbio_in_i(apbio_in), .fpgaio_in_i(fpgaio_in),
    .io_in_i(io_in), .io_out_i(io_out), .io_oe_i(io_oe),
    .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
  );

  // drives are {out, oe}, expected ins ordered perio, apbio, fpgaio
  task automatic add_row(input string name, input logic [PAD_W-1:0] pad, input pad_sel_e sel,
                         input grp_drive_t per, input grp_drive_t apb, input grp_drive_t fpg,
                         input logic [N_IO-1:0] pin, input bit fixed, input logic e_out,
                         input logic e_oe, input logic [2:0] e_in);
    row_t r;
    r.name   = name;
    r.pad    = pad;
    r.sel    = sel;
    r.perio  = per;
    r.apbio  = apb;
    r.fpgaio = fpg;
    r.io_in  = pin;
    r.fixed  = fixed;
    r.e_out  = e_out;
    r.e_oe   = e_oe;
    r.e_in   = e_in;
    rows.push_back(r);
  endtask

  // four-phase write, data is stable one cycle before req
  task automatic cfg_write(input logic [PAD_W-1:0] pad, input pad_sel_e sel);
    @(posedge ref_clk);
    #2;
    cfg_req.pad = pad;
    cfg_req.sel = sel;
    @(posedge ref_clk);
    #2;
    cfg_req_valid = 1'b1;
    do begin
      @(posedge ref_clk);
      #2;
    end while (!cfg_ack);
    cfg_req_valid = 1'b0;
    do begin
      @(posedge ref_clk);
      #2;
    end while (cfg_ack);
  endtask

  // ************************************************************
  // main sequence
  // ************************************************************

  initial begin : main
    int asrt_fail;
    void'($urandom(48));
    add_row("perio_pad0", 3'd0, SEL_PERIO, 16'hA50F, 16'h00FF, 16'hFF00, 8'h01, 1, 1, 1, 3'b100);
    add_row("apbio_pad3", 3'd3, SEL_APBIO, 16'hFFFF, 16'h0808, 16'hFFFF, 8'h08, 1, 1, 1, 3'b010);
    add_row("fpgaio_pad7", 3'd7, SEL_FPGAIO, 16'hFFFF, 16'hFFFF, 16'h0080, 8'h80, 1, 0, 1, 3'b001);
    add_row("apbio_pad3_low", 3'd3, SEL_APBIO, 16'hFFFF, 16'h0008, 16'hFFFF, 8'h00, 1, 0, 1, 3'b000);
    add_row("none_pad0", 3'd0, SEL_NONE, 16'hFFFF, 16'hFFFF, 16'hFFFF, 8'hFF, 1, 0, 0, 3'b000);
    add_row("perio_pad5", 3'd5, SEL_PERIO, 16'h2000, 16'hFFFF, 16'hFFFF, 8'h20, 1, 1, 0, 3'b100);
    for (int n = 0; n < N_RAND; n++) begin
      add_row($sformatf("rand_%0d", n), PAD_W'($urandom_range(0, N_IO - 1)),
              pad_sel_e'($urandom_range(0, 3)), grp_drive_t'($urandom),
              grp_drive_t'($urandom), grp_drive_t'($urandom), N_IO'($urandom),
              0, 0, 0, 3'b000);
    end
    repeat (4) @(posedge ref_clk);
    #2;
    rst_n = 1'b1;
    do begin
      @(posedge ref_clk);
      #2;
    end while (!rst_n_o);
    // busy groups must not reach unselected pads
    u_checker.set_test("reset_idle");
    perio_drv  = '1;
    apbio_drv  = '1;
    fpgaio_drv = '1;
    io_in      = '1;
    repeat (4) @(posedge ref_clk);
    foreach (rows[k]) begin
      u_checker.set_test(rows[k].name);
      cfg_write(rows[k].pad, rows[k].sel);
      @(posedge ref_clk);
      #2;
      perio_drv  = rows[k].perio;
      apbio_drv  = rows[k].apbio;
      fpgaio_drv = rows[k].fpgaio;
      io_in      = rows[k].io_in;
      @(posedge ref_clk);
      #10;
      if (rows[k].fixed) begin
        u_checker.compare_pad(int'(rows[k].pad), rows[k].e_out, rows[k].e_oe, rows[k].e_in);
      end
    end
    repeat (2) @(posedge ref_clk);
    // failures of the bound handshake and reset assertions
    asrt_fail = u_dut.u_pad_mux_regs.u_hs_props.fail_cnt
              + u_dut.u_clk_rst_gen.u_rst_props.fail_cnt;
    $display("checks %0d errors %0d assertion failures %0d", chk_cnt, err_cnt, asrt_fail);
    if (err_cnt == 0 && asrt_fail == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // limit scales with the number of rows
  initial begin : watchdog
    int limit;
    #1;
    limit = rows.size() * 4 * (SYNC_STAGES + 1) * 40 + 2000;
    #(limit);
    $display("timeout, the run did not finish within %0d ns", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: sim.f
hw/pad_pkg.sv
hw/cfg_pkg.sv
hw/clk_rst_gen.sv
hw/pad_mux_regs.sv
hw/pad_control.sv
hw/safe_domain.sv
dv/safe_domain_properties.sv
dv/safe_domain_checker.sv
dv/tb_safe_domain.sv

// File: run_sim.sh
#!/bin/sh
# build and run the safe domain testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_safe_domain \
  -f sim.f -o tb_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "^TESTS PASSED$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
